/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dcache_tb
FILELIST  = src.f
PASS_MSG  = ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* logic/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

    // address and data widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // 32-byte lines, 128 sets, 20-bit tag
    localparam int OFFSET_W       = 5;
    localparam int INDEX_W        = 7;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WORDS_PER_LINE = 8;
    localparam int NUM_SETS       = 1 << INDEX_W;
    localparam int WORD_SEL_W     = 3;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

endpackage

`default_nettype wire

/* logic/dcache_load_return.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_load_return import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    lookup_if.user lk,
    input  logic   hit_way0_i,
    input  logic   hit_way1_i,
    input  line_t  line0_i,
    input  line_t  line1_i,
    input  line_t  ret_data_i,
    input  logic   refilled_i,
    output logic   resp_valid_o,
    output word_t  resp_rdata_o
);

    logic load_hit;

    assign load_hit = lk.valid && (lk.op == OP_LOAD) && (hit_way0_i || hit_way1_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= load_hit || refilled_i;  // one pulse per load
        end
    end

    always_ff @(posedge clk) begin
        if (load_hit) begin
            resp_rdata_o <= hit_way1_i ? line1_i[lk.word_sel] : line0_i[lk.word_sel];
        end else if (refilled_i) begin
            resp_rdata_o <= ret_data_i[lk.word_sel];
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    // request side
    input  logic    req_valid_i,
    input  mem_op_e req_op_i,
    input  addr_t   req_addr_i,
    input  strb_t   req_wstrb_i,
    input  word_t   req_wdata_i,
    input  logic    accept_i,
    // stored tags of the set read last cycle
    input  tag_t    tag0_i,
    input  tag_t    tag1_i,
    input  logic    valid0_i,
    input  logic    valid1_i,
    output index_t  rd_index_o,
    output logic    hit_way0_o,
    output logic    hit_way1_o,
    lookup_if.lookup lk
);

    index_t req_index;

    assign req_index = req_addr_i[OFFSET_W +: INDEX_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            lk.valid <= 1'b0;
        end else if (accept_i) begin
            lk.valid <= req_valid_i;
        end
    end

    // payload, only meaningful with lk.valid
    always_ff @(posedge clk) begin
        if (accept_i) begin
            lk.op       <= req_op_i;
            lk.index    <= req_index;
            lk.tag      <= req_addr_i[ADDR_W-1 -: TAG_W];
            lk.word_sel <= req_addr_i[OFFSET_W-WORD_SEL_W +: WORD_SEL_W];
            lk.wstrb    <= req_wstrb_i;
            lk.wdata    <= req_wdata_i;
        end
    end

    // next request's set while accepting, else keep reading the held set
    assign rd_index_o = accept_i ? req_index : lk.index;

    assign hit_way0_o = valid0_i && (tag0_i == lk.tag);
    assign hit_way1_o = valid1_i && (tag1_i == lk.tag);

endmodule

`default_nettype wire

/* logic/dcache_miss_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    lookup_if.user lk,
    input  logic   hit_way0_i,
    input  logic   hit_way1_i,
    input  tag_t   tag0_i,
    input  tag_t   tag1_i,
    input  line_t  line0_i,
    input  line_t  line1_i,
    // memory side
    input  logic   ret_valid_i,
    input  line_t  ret_data_i,
    input  logic   wr_done_i,
    output logic   accept_o,
    // to the ways
    output logic   store_hit_en_o,
    output logic   store_way_o,
    output logic   refill_en_o,
    output logic   refill_way_o,
    output line_t  ret_line_o,
    output logic   rd_req_o,
    output addr_t  rd_addr_o,
    output logic   wr_req_o,
    output addr_t  wr_addr_o,
    output line_t  wr_data_o,
    output logic   refilled_o
);

    miss_state_e state_q;
    miss_state_e state_d;

    logic [NUM_SETS-1:0]      lru_q;  // way to evict next
    logic [1:0][NUM_SETS-1:0] dirty_q;

    logic  lookup;
    logic  hit;
    logic  miss;
    logic  victim;
    logic  victim_dirty;
    addr_t wb_addr_q;
    line_t wb_line_q;
    line_t ret_line_q;

    assign lookup       = (state_q == ST_IDLE) && lk.valid;
    assign hit          = hit_way0_i || hit_way1_i;
    assign miss         = lookup && !hit;
    assign victim       = lru_q[lk.index];
    assign victim_dirty = dirty_q[victim][lk.index];

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    state_d = victim_dirty ? ST_WRITEBACK : ST_REFILL_WAIT;
                end else if (lookup && lk.op == OP_STORE) begin
                    state_d = ST_RETURN;  // store hit
                end
            end
            ST_WRITEBACK: begin
                if (wr_done_i) state_d = ST_REFILL_WAIT;
            end
            ST_REFILL_WAIT: begin
                if (ret_valid_i) state_d = ST_REFILL;
            end
            ST_REFILL: state_d = ST_RETURN;
            ST_RETURN: state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    // idle next cycle: nothing pending, or a load that hits
    assign accept_o = ((state_q == ST_IDLE) && !(lk.valid && (!hit || lk.op == OP_STORE)))
                      || (state_q == ST_RETURN);

    assign store_hit_en_o = lookup && hit && (lk.op == OP_STORE);
    assign store_way_o    = hit_way1_i;
    assign refill_en_o    = (state_q == ST_REFILL);
    assign refill_way_o   = victim;
    assign refilled_o     = refill_en_o && (lk.op == OP_LOAD);
    assign ret_line_o     = ret_line_q;

    assign rd_req_o  = (state_q == ST_REFILL_WAIT);
    assign rd_addr_o = {lk.tag, lk.index, {OFFSET_W{1'b0}}};
    assign wr_req_o  = (state_q == ST_WRITEBACK);
    assign wr_addr_o = wb_addr_q;
    assign wr_data_o = wb_line_q;

    always_ff @(posedge clk) begin
        if (miss && victim_dirty) begin
            wb_addr_q <= {victim ? tag1_i : tag0_i, lk.index, {OFFSET_W{1'b0}}};
            wb_line_q <= victim ? line1_i : line0_i;
        end
        if (state_q == ST_REFILL_WAIT && ret_valid_i) begin
            ret_line_q <= ret_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else if (lookup && hit) begin
            lru_q[lk.index] <= hit_way0_i;  // away from the used way
            if (lk.op == OP_STORE) begin
                dirty_q[hit_way1_i][lk.index] <= 1'b1;
            end
        end else if (refill_en_o) begin
            lru_q[lk.index]           <= ~victim;
            dirty_q[victim][lk.index] <= (lk.op == OP_STORE);
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    req_valid_i,
    input  mem_op_e req_op_i,
    input  addr_t   req_addr_i,
    input  strb_t   req_wstrb_i,
    input  word_t   req_wdata_i,
    output logic    req_ready_o,
    output logic    resp_valid_o,
    output word_t   resp_rdata_o,
    // line read
    output logic    rd_req_o,
    output addr_t   rd_addr_o,
    input  logic    ret_valid_i,
    input  line_t   ret_data_i,
    // line write-back
    output logic    wr_req_o,
    output addr_t   wr_addr_o,
    output line_t   wr_data_o,
    input  logic    wr_done_i
);

    lookup_if lk ();

    logic   accept;
    index_t rd_index;
    logic   hit_way0, hit_way1;
    tag_t   tag0, tag1;
    logic   valid0, valid1;
    line_t  line0, line1;
    logic   store_hit_en, store_way;
    logic   refill_en, refill_way;
    line_t  ret_line;
    logic   refilled;

    assign req_ready_o = accept;

    dcache_lookup u_lookup (
        .clk(clk), .reset(reset),
        .req_valid_i(req_valid_i), .req_op_i(req_op_i), .req_addr_i(req_addr_i),
        .req_wstrb_i(req_wstrb_i), .req_wdata_i(req_wdata_i),
        .accept_i(accept),
        .tag0_i(tag0), .tag1_i(tag1), .valid0_i(valid0), .valid1_i(valid1),
        .rd_index_o(rd_index), .hit_way0_o(hit_way0), .hit_way1_o(hit_way1),
        .lk(lk)
    );

    dcache_ways u_ways (
        .clk(clk), .reset(reset), .lk(lk), .rd_index_i(rd_index),
        .store_hit_en_i(store_hit_en), .store_way_i(store_way),
        .refill_en_i(refill_en), .refill_way_i(refill_way), .ret_line_i(ret_line),
        .tag0_o(tag0), .tag1_o(tag1), .valid0_o(valid0), .valid1_o(valid1),
        .line0_o(line0), .line1_o(line1)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk(clk), .reset(reset), .lk(lk),
        .hit_way0_i(hit_way0), .hit_way1_i(hit_way1), .tag0_i(tag0), .tag1_i(tag1),
        .line0_i(line0), .line1_i(line1),
        .ret_valid_i(ret_valid_i), .ret_data_i(ret_data_i), .wr_done_i(wr_done_i),
        .accept_o(accept), .store_hit_en_o(store_hit_en), .store_way_o(store_way),
        .refill_en_o(refill_en), .refill_way_o(refill_way), .ret_line_o(ret_line),
        .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o),
        .wr_req_o(wr_req_o), .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o),
        .refilled_o(refilled)
    );

    // refill word comes from the held return line
    dcache_load_return u_load_return (
        .clk(clk), .reset(reset), .lk(lk),
        .hit_way0_i(hit_way0), .hit_way1_i(hit_way1), .line0_i(line0), .line1_i(line1),
        .ret_data_i(ret_line), .refilled_i(refilled),
        .resp_valid_o(resp_valid_o), .resp_rdata_o(resp_rdata_o)
    );

endmodule

`default_nettype wire

/* logic/dcache_ways.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ways import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    lookup_if.user lk,
    input  index_t rd_index_i,
    input  logic   store_hit_en_i,
    input  logic   store_way_i,
    input  logic   refill_en_i,
    input  logic   refill_way_i,
    input  line_t  ret_line_i,
    output tag_t   tag0_o,
    output tag_t   tag1_o,
    output logic   valid0_o,
    output logic   valid1_o,
    output line_t  line0_o,
    output line_t  line1_o
);

    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_t                tag_mem  [NUM_SETS];
        word_t               data_mem [NUM_SETS][WORDS_PER_LINE];
        logic [NUM_SETS-1:0] valid_q;
        tag_t                tag_rd;
        line_t               line_rd;
        logic                valid_rd;
        logic                store_we;
        logic                refill_we;

        assign store_we  = store_hit_en_i && (store_way_i == 1'(w));
        assign refill_we = refill_en_i && (refill_way_i == 1'(w));

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q  <= '0;
                valid_rd <= 1'b0;
            end else begin
                valid_rd <= valid_q[rd_index_i];
                if (refill_we) begin
                    valid_q[lk.index] <= 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            // read sees the old contents on a same-edge write
            tag_rd <= tag_mem[rd_index_i];
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
                line_rd[i] <= data_mem[rd_index_i][i];
            end

            if (refill_we) begin
                tag_mem[lk.index] <= lk.tag;
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    data_mem[lk.index][i] <= ret_line_i[i];
                end
            end

            // store bytes land over the refilled word too
            if (store_we || (refill_we && lk.op == OP_STORE)) begin
                for (int b = 0; b < WORD_W/8; b++) begin
                    if (lk.wstrb[b]) begin
                        data_mem[lk.index][lk.word_sel][8*b +: 8] <= lk.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assign tag0_o   = g_way[0].tag_rd;
    assign tag1_o   = g_way[1].tag_rd;
    assign valid0_o = g_way[0].valid_rd;
    assign valid1_o = g_way[1].valid_rd;
    assign line0_o  = g_way[0].line_rd;
    assign line1_o  = g_way[1].line_rd;

endmodule

`default_nettype wire

/* logic/lookup_if.sv */
`timescale 1ns/1ps
`default_nettype none

// captured request, held while the controller works on it
interface lookup_if import cache_geom_pkg::*, mem_bus_pkg::*; ();

    logic      valid;
    mem_op_e   op;
    index_t    index;
    tag_t      tag;
    word_sel_t word_sel;
    strb_t     wstrb;
    word_t     wdata;

    modport lookup (
        output valid, op, index, tag,
        output word_sel, wstrb, wdata
    );

    modport user (
        input valid, op, index, tag,
        input word_sel, wstrb, wdata
    );

endinterface

`default_nettype wire

/* logic/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;
    import cache_geom_pkg::*;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    typedef logic [WORD_W/8-1:0] strb_t;      // one bit per byte
    typedef word_t [WORDS_PER_LINE-1:0] line_t;  // word 0 in the low bits

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_REFILL_WAIT,
        ST_REFILL,
        ST_RETURN
    } miss_state_e;

endpackage

`default_nettype wire

/* src.f */
logic/cache_geom_pkg.sv
logic/mem_bus_pkg.sv
logic/lookup_if.sv
logic/dcache_lookup.sv
logic/dcache_ways.sv
logic/dcache_miss_ctrl.sv
logic/dcache_load_return.sv
logic/dcache_top.sv
tests/dcache_chk.sv
tests/dcache_tb.sv

/* tests/dcache_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_chk import cache_geom_pkg::*, mem_bus_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    req_valid_i,
    input logic    req_ready_o,
    input mem_op_e req_op_i,
    input logic    resp_valid_o,
    input logic    rd_req_o,
    input logic    wr_req_o,
    input addr_t   wr_addr_o,
    input line_t   wr_data_o
);

    int loads_pending;
    int fails_excl = 0;
    int fails_resp = 0;
    int fails_wb   = 0;
    int fail_cnt;  // read by the testbench at the end

    assign fail_cnt = fails_excl + fails_resp + fails_wb;

    always_ff @(posedge clk) begin
        if (reset) begin
            loads_pending <= 0;
        end else begin
            loads_pending <= loads_pending
                + ((req_valid_i && req_ready_o && req_op_i == OP_LOAD) ? 1 : 0)
                - (resp_valid_o ? 1 : 0);
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(rd_req_o && wr_req_o))
        else begin
            $error("rd_req_o and wr_req_o high together");
            fails_excl++;
        end

    // each pulse must belong to an outstanding load
    a_resp_once: assert property (@(posedge clk) disable iff (reset)
        resp_valid_o |-> (loads_pending > 0))
        else begin
            $error("resp_valid_o without an outstanding load");
            fails_resp++;
        end

    a_wb_stable: assert property (@(posedge clk) disable iff (reset)
        (wr_req_o && $past(wr_req_o)) |-> ($stable(wr_addr_o) && $stable(wr_data_o)))
        else begin
            $error("write-back address or data changed while wr_req_o high");
            fails_wb++;
        end

endmodule

bind dcache_top dcache_chk chk_i (
    .clk(clk), .reset(reset),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
    .resp_valid_o(resp_valid_o), .rd_req_o(rd_req_o), .wr_req_o(wr_req_o),
    .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o)
);

`default_nettype wire

/* tests/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import cache_geom_pkg::*, mem_bus_pkg::*; ();

    localparam int RAND_OPS    = 300;
    localparam int NUM_OPS     = 15 + RAND_OPS;
    localparam int CYCLE_LIMIT = 40 * NUM_OPS;

    logic    clk = 1'b0;
    logic    reset = 1'b1;
    logic    req_valid_i = 1'b0;
    mem_op_e req_op_i = OP_LOAD;
    addr_t   req_addr_i = '0;
    strb_t   req_wstrb_i = '0;
    word_t   req_wdata_i = '0;
    logic    req_ready_o;
    logic    resp_valid_o;
    word_t   resp_rdata_o;
    logic    rd_req_o;
    addr_t   rd_addr_o;
    logic    ret_valid_i = 1'b0;
    line_t   ret_data_i = '0;
    logic    wr_req_o;
    addr_t   wr_addr_o;
    line_t   wr_data_o;
    logic    wr_done_i = 1'b0;

    word_t       gold_mem [addr_t];  // what the core should see
    word_t       back_mem [addr_t];  // what memory holds
    word_t       exp_q [$];
    logic [31:0] lfsr_q = 32'h9d30;
    int          val_errs = 0;
    int          other_errs = 0;
    int          wb_cnt = 0;
    addr_t       last_wb_addr = '0;

    mem_op_e rnd_op   [RAND_OPS];
    addr_t   rnd_addr [RAND_OPS];
    strb_t   rnd_strb [RAND_OPS];
    word_t   rnd_data [RAND_OPS];

    dcache_top dut_i (
        .clk(clk), .reset(reset),
        .req_valid_i(req_valid_i), .req_op_i(req_op_i), .req_addr_i(req_addr_i),
        .req_wstrb_i(req_wstrb_i), .req_wdata_i(req_wdata_i), .req_ready_o(req_ready_o),
        .resp_valid_o(resp_valid_o), .resp_rdata_o(resp_rdata_o),
        .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o),
        .ret_valid_i(ret_valid_i), .ret_data_i(ret_data_i),
        .wr_req_o(wr_req_o), .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o),
        .wr_done_i(wr_done_i)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    function automatic int rand_delay();
        return 1 + int'(rand_bits(3) % 6);
    endfunction

    function automatic addr_t mk_addr(input tag_t t, input index_t ix, input word_sel_t w);
        return {t, ix, w, 2'b00};
    endfunction

    function automatic word_t fill_pattern(input addr_t a);
        return (a * 32'h0001_0003) ^ 32'ha5c3_1e0f;
    endfunction

    function automatic word_t gold_read(input addr_t a);
        if (gold_mem.exists(a)) begin
            return gold_mem[a];
        end
        return fill_pattern(a);
    endfunction

    function automatic word_t back_read(input addr_t a);
        if (back_mem.exists(a)) begin
            return back_mem[a];
        end
        return fill_pattern(a);
    endfunction

    // byte-wise store merge
    function automatic word_t ref_merge(input word_t old_w, input word_t new_w,
                                        input strb_t strb);
        word_t r;
        r = old_w;
        for (int b = 0; b < WORD_W/8; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            val_errs++;
        end
    endtask

    // called just after a rising edge, returns just after the edge that took it
    task automatic issue(input mem_op_e op, input addr_t addr, input strb_t strb,
                         input word_t data);
        addr_t wa;
        wa = {addr[ADDR_W-1:2], 2'b00};
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_wstrb_i = strb;
        req_wdata_i = data;
        while (!req_ready_o) begin
            @(posedge clk);
            #1;
        end
        if (op == OP_LOAD) begin
            exp_q.push_back(gold_read(wa));
        end else begin
            gold_mem[wa] = ref_merge(gold_read(wa), data, strb);
        end
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0 || !req_ready_o) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin
        if (!reset && resp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("load response arrived with no load outstanding");
                other_errs++;
            end else begin
                check_word("resp_rdata_o", resp_rdata_o, exp_q.pop_front());
            end
        end
    end

    initial begin : mem_read
        int    d;
        addr_t base;
        wait (!reset);
        forever begin
            @(posedge clk);
            #1;
            if (rd_req_o) begin
                d = rand_delay();
                repeat (d - 1) begin
                    @(posedge clk);
                    #1;
                end
                base = rd_addr_o;
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    ret_data_i[i] = back_read(base + addr_t'(4 * i));
                end
                ret_valid_i = 1'b1;
                @(posedge clk);
                #1;
                ret_valid_i = 1'b0;
            end
        end
    end

    initial begin : mem_write
        int d;
        wait (!reset);
        forever begin
            @(posedge clk);
            #1;
            if (wr_req_o) begin
                // a dirty line must match what the core has stored
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    check_word("wr_data_o", wr_data_o[i], gold_read(wr_addr_o + addr_t'(4 * i)));
                end
                d = rand_delay();
                repeat (d - 1) begin
                    @(posedge clk);
                    #1;
                end
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    back_mem[wr_addr_o + addr_t'(4 * i)] = wr_data_o[i];
                end
                last_wb_addr = wr_addr_o;
                wb_cnt++;
                wr_done_i = 1'b1;
                @(posedge clk);
                #1;
                wr_done_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        addr_t a;
        int    wb_before;
        int    total;
        // 4 sets, 3 tags, so sets overflow
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd_op[n]   = (rand_bits(1) == 0) ? OP_LOAD : OP_STORE;
            rnd_addr[n] = mk_addr(tag_t'(32'h100 + rand_bits(2) % 3),
                                  index_t'(16 + rand_bits(2)), word_sel_t'(rand_bits(3)));
            rnd_strb[n] = strb_t'(rand_bits(4));
            rnd_data[n] = word_t'(rand_bits(32));
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        check_flag("req_ready_o", req_ready_o, 1'b1);
        check_flag("rd_req_o", rd_req_o, 1'b0);
        check_flag("wr_req_o", wr_req_o, 1'b0);
        a = mk_addr(20'h00010, 7'd5, 3'd3);
        issue(OP_LOAD, a, '0, '0);  // cold miss
        while (!rd_req_o) begin
            @(posedge clk);
            #1;
        end
        check_addr("rd_addr_o", rd_addr_o, mk_addr(20'h00010, 7'd5, 3'd0));
        wait_idle();

        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            issue(OP_LOAD, mk_addr(20'h00010, 7'd5, word_sel_t'(w)), '0, '0);
        end
        wait_idle();

        issue(OP_STORE, a, 4'b0101, 32'h1122_3344);
        issue(OP_LOAD, a, '0, '0);
        wait_idle();

        // third tag in set 9 pushes out the first
        wb_before = wb_cnt;
        issue(OP_STORE, mk_addr(20'h00a01, 7'd9, 3'd1), 4'b1111, 32'hdead_beef);
        issue(OP_STORE, mk_addr(20'h00a02, 7'd9, 3'd6), 4'b0011, 32'h0bad_f00d);
        issue(OP_STORE, mk_addr(20'h00a03, 7'd9, 3'd2), 4'b1100, 32'h5555_aaaa);
        wait_idle();
        if (wb_cnt != wb_before + 1) begin
            $display("expected one write-back on the third tag, saw %0d", wb_cnt - wb_before);
            other_errs++;
        end
        check_addr("wr_addr_o", last_wb_addr, mk_addr(20'h00a01, 7'd9, 3'd0));

        issue(OP_LOAD, mk_addr(20'h00a01, 7'd9, 3'd1), '0, '0);
        wait_idle();

        for (int n = 0; n < RAND_OPS; n++) begin
            issue(rnd_op[n], rnd_addr[n], rnd_strb[n], rnd_data[n]);
        end
        wait_idle();
        repeat (4) @(posedge clk);

        total = val_errs + other_errs + dut_i.chk_i.fail_cnt;
        $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
                 val_errs, other_errs, dut_i.chk_i.fail_cnt);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
